// File: logic/tetris_pkg.sv
// Falling block game definitions

package tetris_pkg;

	// ------------------------------------------------------------------
	// board geometry
	// ------------------------------------------------------------------
	localparam int BOARD_COLS = 6;
	localparam int VIS_ROWS   = 12;
	// three hidden rows above the visible board catch overflow
	localparam int ALL_ROWS   = 15;

	// bit c is column c
	typedef logic [BOARD_COLS-1:0] row_t;
	typedef logic [3:0]            row_idx_t;
	typedef logic [2:0]            col_idx_t;

	// row 0 at the bottom
	typedef row_t [ALL_ROWS-1:0] board_t;

	// visible part, seen either as rows or as the flat result word
	typedef union packed {
		row_t [VIS_ROWS-1:0]               rows;
		logic [VIS_ROWS*BOARD_COLS-1:0]    flat;
	} board_view_u;

	typedef struct packed {
		col_idx_t col;
		row_idx_t row;
	} cell_t;

	// board update strobes from the controller
	typedef struct packed {
		logic     place;
		logic     collapse;
		logic     wipe;
		logic     report;
		row_idx_t row;
	} board_cmd_t;

	// ------------------------------------------------------------------
	// shape table
	// ------------------------------------------------------------------
	// column offset, then row offset above the landing row
	typedef struct packed {
		logic [1:0] dc;
		logic [1:0] dr;
	} cell_off_t;

	typedef cell_off_t [0:3] shape_t;

	localparam shape_t SHAPE_CELLS [0:7] = '{
		'{'{2'd0, 2'd0}, '{2'd0, 2'd1}, '{2'd1, 2'd0}, '{2'd1, 2'd1}},
		'{'{2'd0, 2'd0}, '{2'd0, 2'd1}, '{2'd0, 2'd2}, '{2'd0, 2'd3}},
		'{'{2'd0, 2'd0}, '{2'd1, 2'd0}, '{2'd2, 2'd0}, '{2'd3, 2'd0}},
		'{'{2'd0, 2'd2}, '{2'd1, 2'd0}, '{2'd1, 2'd1}, '{2'd1, 2'd2}},
		'{'{2'd0, 2'd0}, '{2'd0, 2'd1}, '{2'd1, 2'd1}, '{2'd2, 2'd1}},
		'{'{2'd0, 2'd0}, '{2'd1, 2'd0}, '{2'd0, 2'd1}, '{2'd0, 2'd2}},
		'{'{2'd1, 2'd0}, '{2'd1, 2'd1}, '{2'd0, 2'd1}, '{2'd0, 2'd2}},
		'{'{2'd0, 2'd0}, '{2'd1, 2'd0}, '{2'd1, 2'd1}, '{2'd2, 2'd1}}
	};

endpackage

// File: logic/line_check.sv
// Full row and overflow detection
`timescale 1ns/1ns

module line_check (
	input  tetris_pkg::board_t   board,
	output logic                 has_full,
	output logic                 overflow,
	output tetris_pkg::row_idx_t low_full
);

	logic [tetris_pkg::VIS_ROWS-1:0] full;

	// only visible rows can be cleared
	always_comb begin
		for (int r = 0; r < tetris_pkg::VIS_ROWS; r++) begin
			full[r] = &board[r];
		end
	end

	assign has_full = |full;

	// lowest full row wins
	always_comb begin
		low_full = '0;
		for (int r = tetris_pkg::VIS_ROWS - 1; r >= 0; r--) begin
			if (full[r]) begin
				low_full = tetris_pkg::row_idx_t'(r);
			end
		end
	end

	// any block left in a hidden row
	assign overflow = |board[tetris_pkg::ALL_ROWS-1:tetris_pkg::VIS_ROWS];

endmodule

// File: logic/drop_calc.sv
// Piece landing calculation
`timescale 1ns/1ns

module drop_calc (
	input  tetris_pkg::board_t      board,
	input  logic [2:0]              tetrominoes,
	input  tetris_pkg::col_idx_t    position,
	output tetris_pkg::cell_t [3:0] cells
);

	tetris_pkg::row_idx_t height [tetris_pkg::BOARD_COLS];
	tetris_pkg::row_idx_t land;
	tetris_pkg::shape_t   shape;

	assign shape = tetris_pkg::SHAPE_CELLS[tetrominoes];

	// ------------------------------------------------------------------
	// column heights, one above the highest filled cell
	// ------------------------------------------------------------------
	always_comb begin
		for (int c = 0; c < tetris_pkg::BOARD_COLS; c++) begin
			height[c] = '0;
			for (int r = 0; r < tetris_pkg::ALL_ROWS; r++) begin
				if (board[r][c]) begin
					height[c] = tetris_pkg::row_idx_t'(r + 1);
				end
			end
		end
	end

	// ------------------------------------------------------------------
	// landing row
	// ------------------------------------------------------------------
	// per touched column: height minus lowest offset there, take the max
	always_comb begin
		logic [1:0] min_off;
		logic       touched;
		int         col;
		land = '0;
		for (int d = 0; d < 4; d++) begin
			touched = 1'b0;
			min_off = 2'd3;
			for (int i = 0; i < 4; i++) begin
				if (shape[i].dc == 2'(d)) begin
					touched = 1'b1;
					if (shape[i].dr < min_off) begin
						min_off = shape[i].dr;
					end
				end
			end
			col = int'(position) + d;
			if (touched && col < tetris_pkg::BOARD_COLS) begin
				if (5'(height[col]) > 5'(land) + 5'(min_off)) begin
					land = height[col] - tetris_pkg::row_idx_t'(min_off);
				end
			end
		end
	end

	// absolute cell coordinates
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			cells[i].col = position + tetris_pkg::col_idx_t'(shape[i].dc);
			cells[i].row = land + tetris_pkg::row_idx_t'(shape[i].dr);
		end
	end

endmodule

// File: logic/board_store.sv
// Board register
`timescale 1ns/1ns

module board_store (
	input  logic                    clk,
	input  logic                    rst_n,
	input  tetris_pkg::board_cmd_t  cmd,
	input  tetris_pkg::cell_t [3:0] cells,
	output tetris_pkg::board_t      board,
	output logic [71:0]             tetris
);

	tetris_pkg::board_t      board_nxt;
	tetris_pkg::board_view_u view;

	always_comb begin
		board_nxt = board;
		// set the four cells of the new piece
		if (cmd.place) begin
			for (int i = 0; i < 4; i++) begin
				if (cells[i].row < tetris_pkg::ALL_ROWS &&
				    cells[i].col < tetris_pkg::BOARD_COLS) begin
					board_nxt[cells[i].row][cells[i].col] = 1'b1;
				end
			end
		end
		// drop everything above the cleared row by one
		if (cmd.collapse) begin
			for (int r = 0; r < tetris_pkg::ALL_ROWS - 1; r++) begin
				if (r >= int'(cmd.row)) begin
					board_nxt[r] = board[r+1];
				end
			end
			board_nxt[tetris_pkg::ALL_ROWS-1] = '0;
		end
		if (cmd.wipe) begin
			board_nxt = '0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			board <= '0;
		end else begin
			board <= board_nxt;
		end
	end

	// ------------------------------------------------------------------
	// result snapshot
	// ------------------------------------------------------------------
	always_comb view.rows = board[tetris_pkg::VIS_ROWS-1:0];

	// taken before any wipe on the same edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tetris <= '0;
		end else begin
			tetris <= cmd.report ? view.flat : '0;
		end
	end

endmodule

// File: logic/game_ctrl.sv
// Game controller
`timescale 1ns/1ns

module game_ctrl #(
	parameter int GAME_PIECES = 16
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   in_valid,
	input  logic                   has_full,
	input  logic                   overflow,
	input  tetris_pkg::row_idx_t   low_full,
	output tetris_pkg::board_cmd_t cmd,
	output logic                   score_valid,
	output logic                   tetris_valid,
	output logic                   fail,
	output logic [3:0]             score
);

	localparam int CNT_W = $clog2(GAME_PIECES + 1);

	typedef enum logic {
		IDLE,
		CLEAR
	} state_t;

	state_t           state;
	logic [CNT_W-1:0] piece_cnt;
	logic [3:0]       score_acc;
	logic             game_end;

	// topped out or last piece of the game
	assign game_end = overflow || (piece_cnt == CNT_W'(GAME_PIECES));

	// ------------------------------------------------------------------
	// board commands
	// ------------------------------------------------------------------
	always_comb begin
		cmd     = '0;
		cmd.row = low_full;
		case (state)
			IDLE: begin
				cmd.place = in_valid;
			end
			CLEAR: begin
				if (has_full) begin
					cmd.collapse = 1'b1;
				end else begin
					cmd.report = 1'b1;
					cmd.wipe   = game_end;
				end
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else if (state == IDLE && in_valid) begin
			state <= CLEAR;
		end else if (state == CLEAR && !has_full) begin
			state <= IDLE;
		end
	end

	// ------------------------------------------------------------------
	// piece count and running score
	// ------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			piece_cnt <= '0;
			score_acc <= '0;
		end else if (cmd.wipe) begin
			piece_cnt <= '0;
			score_acc <= '0;
		end else begin
			if (cmd.place) begin
				piece_cnt <= piece_cnt + 1'b1;
			end
			// one point per removed row
			if (cmd.collapse) begin
				score_acc <= score_acc + 4'd1;
			end
		end
	end

	// one cycle result pulse
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			score_valid  <= 1'b0;
			tetris_valid <= 1'b0;
			fail         <= 1'b0;
			score        <= '0;
		end else if (cmd.report) begin
			score_valid  <= 1'b1;
			tetris_valid <= 1'b1;
			fail         <= overflow;
			score        <= score_acc;
		end else begin
			score_valid  <= 1'b0;
			tetris_valid <= 1'b0;
			fail         <= 1'b0;
			score        <= '0;
		end
	end

endmodule

// File: logic/tetris_top.sv
// Falling block game engine top
`timescale 1ns/1ns

module tetris_top #(
	parameter int GAME_PIECES = 16
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        in_valid,
	input  logic [2:0]  tetrominoes,
	input  logic [2:0]  position,
	output logic        score_valid,
	output logic        tetris_valid,
	output logic        fail,
	output logic [3:0]  score,
	output logic [71:0] tetris
);

	tetris_pkg::board_t       board;
	tetris_pkg::cell_t [3:0]  cells;
	tetris_pkg::board_cmd_t   cmd;
	tetris_pkg::row_idx_t     low_full;
	logic                     has_full;
	logic                     overflow;

	game_ctrl #(
		.GAME_PIECES (GAME_PIECES)
	) u_game_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.in_valid     (in_valid),
		.has_full     (has_full),
		.overflow     (overflow),
		.low_full     (low_full),
		.cmd          (cmd),
		.score_valid  (score_valid),
		.tetris_valid (tetris_valid),
		.fail         (fail),
		.score        (score)
	);

	drop_calc u_drop_calc (
		.board       (board),
		.tetrominoes (tetrominoes),
		.position    (position),
		.cells       (cells)
	);

	board_store u_board_store (
		.clk    (clk),
		.rst_n  (rst_n),
		.cmd    (cmd),
		.cells  (cells),
		.board  (board),
		.tetris (tetris)
	);

	line_check u_line_check (
		.board    (board),
		.has_full (has_full),
		.overflow (overflow),
		.low_full (low_full)
	);

endmodule

// File: testbench/tb_vectors.svh
// Piece and result table
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

typedef struct packed {
	logic [2:0]  shape;
	logic [2:0]  pos;
	logic [3:0]  score;
	logic        fail;
	logic [71:0] board;
} vector_t;

localparam int NUM_VECTORS = 22;

// shape, column, score, fail, visible rows listed from the top row down
localparam vector_t VECTORS [0:NUM_VECTORS-1] = '{
	// game one, sixteen pieces
	'{3'd2, 3'd0, 4'd0, 1'b0, {66'd0, 6'b001111}},
	'{3'd0, 3'd4, 4'd1, 1'b0, {66'd0, 6'b110000}},
	'{3'd0, 3'd2, 4'd1, 1'b0, {60'd0, 6'b001100, 6'b111100}},
	'{3'd1, 3'd4, 4'd1, 1'b0, {42'd0, 6'b010000, 6'b010000, 6'b010000, 6'b011100, 6'b111100}},
	'{3'd1, 3'd5, 4'd1, 1'b0, {42'd0, 6'b110000, 6'b110000, 6'b110000, 6'b111100, 6'b111100}},
	'{3'd0, 3'd0, 4'd3, 1'b0, {54'd0, 6'b110000, 6'b110000, 6'b110000}},
	'{3'd3, 3'd0, 4'd3, 1'b0, {54'd0, 6'b110011, 6'b110010, 6'b110010}},
	'{3'd7, 3'd2, 4'd4, 1'b0, {54'd0, 6'b011000, 6'b110010, 6'b110010}},
	'{3'd5, 3'd0, 4'd4, 1'b0, {42'd0, 6'b000001, 6'b000001, 6'b011011, 6'b110010, 6'b110010}},
	'{3'd6, 3'd1, 4'd4, 1'b0, {42'd0, 6'b000011, 6'b000111, 6'b011111, 6'b110010, 6'b110010}},
	'{3'd4, 3'd3, 4'd4, 1'b0, {42'd0, 6'b111011, 6'b001111, 6'b011111, 6'b110010, 6'b110010}},
	'{3'd1, 3'd2, 4'd5, 1'b0, {30'd0, 6'b000100, 6'b000100, 6'b000100, 6'b001111,
		6'b011111, 6'b110010, 6'b110010}},
	'{3'd0, 3'd0, 4'd5, 1'b0, {30'd0, 6'b000100, 6'b000111, 6'b000111, 6'b001111,
		6'b011111, 6'b110010, 6'b110010}},
	'{3'd7, 3'd3, 4'd5, 1'b0, {30'd0, 6'b000100, 6'b110111, 6'b011111, 6'b001111,
		6'b011111, 6'b110010, 6'b110010}},
	'{3'd1, 3'd3, 4'd6, 1'b0, {24'd0, 6'b001000, 6'b001000, 6'b001100, 6'b011111,
		6'b001111, 6'b011111, 6'b110010, 6'b110010}},
	'{3'd0, 3'd4, 4'd6, 1'b0, {24'd0, 6'b001000, 6'b111000, 6'b111100, 6'b011111,
		6'b001111, 6'b011111, 6'b110010, 6'b110010}},
	// game two, starts empty and tops out in column 0
	'{3'd3, 3'd4, 4'd0, 1'b0, {54'd0, 6'b110000, 6'b100000, 6'b100000}},
	'{3'd1, 3'd0, 4'd0, 1'b0, {48'd0, 6'b000001, 6'b110001, 6'b100001, 6'b100001}},
	'{3'd1, 3'd0, 4'd0, 1'b0, {24'd0, {5{6'b000001}}, 6'b110001, 6'b100001, 6'b100001}},
	'{3'd1, 3'd0, 4'd0, 1'b0, {{9{6'b000001}}, 6'b110001, 6'b100001, 6'b100001}},
	'{3'd1, 3'd0, 4'd0, 1'b1, {{9{6'b000001}}, 6'b110001, 6'b100001, 6'b100001}},
	// game three, fresh board after the fail
	'{3'd2, 3'd1, 4'd0, 1'b0, {66'd0, 6'b011110}}
};

`endif

// File: testbench/tb_tetris.sv
// Falling block game testbench
`timescale 1ns/1ns

module tb_tetris;

	logic        clk;
	logic        rst_n;
	logic        in_valid;
	logic [2:0]  tetrominoes;
	logic [2:0]  position;
	logic        score_valid;
	logic        tetris_valid;
	logic        fail;
	logic [3:0]  score;
	logic [71:0] tetris;

	int errors;
	int timeouts;

	`include "tb_vectors.svh"

	tetris_top #(
		.GAME_PIECES (16)
	) uut (
		.clk          (clk),
		.rst_n        (rst_n),
		.in_valid     (in_valid),
		.tetrominoes  (tetrominoes),
		.position     (position),
		.score_valid  (score_valid),
		.tetris_valid (tetris_valid),
		.fail         (fail),
		.score        (score),
		.tetris       (tetris)
	);

	always #4 clk = ~clk;

	// ------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------
	task automatic check_value(input string name, input logic [71:0] expected,
	                           input logic [71:0] actual);
		assert (actual === expected) else begin
			$display("FAIL %s expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	// one cycle strobe, driven from a falling edge
	task automatic send_piece(input vector_t v);
		in_valid    = 1'b1;
		tetrominoes = v.shape;
		position    = v.pos;
		@(negedge clk);
		in_valid    = 1'b0;
		tetrominoes = 3'd0;
		position    = 3'd0;
	endtask

	task automatic wait_result(output bit seen);
		int n;
		seen = 1'b0;
		n    = 0;
		while (!seen && n < 40) begin
			if (score_valid) begin
				seen = 1'b1;
			end else begin
				@(negedge clk);
				n++;
			end
		end
	endtask

	task automatic check_idle_outputs(input string tag);
		check_value({tag, " score_valid"}, 72'd0, 72'(score_valid));
		check_value({tag, " tetris_valid"}, 72'd0, 72'(tetris_valid));
		check_value({tag, " fail"}, 72'd0, 72'(fail));
		check_value({tag, " score"}, 72'd0, 72'(score));
		check_value({tag, " tetris"}, 72'd0, tetris);
	endtask

	task automatic finish_run();
		$display("value errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	endtask

	// ------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------
	initial begin
		bit    seen;
		string tag;
		clk         = 1'b0;
		rst_n       = 1'b0;
		in_valid    = 1'b0;
		tetrominoes = 3'd0;
		position    = 3'd0;
		errors      = 0;
		timeouts    = 0;

		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_idle_outputs("reset");

		for (int i = 0; i < NUM_VECTORS; i++) begin
			tag = $sformatf("piece %0d", i);
			send_piece(VECTORS[i]);
			wait_result(seen);
			if (!seen) begin
				$display("timeout: no result for %s within 40 cycles", tag);
				timeouts++;
				break;
			end
			// result pulse fields
			check_value({tag, " tetris_valid"}, 72'd1, 72'(tetris_valid));
			check_value({tag, " score"}, 72'(VECTORS[i].score), 72'(score));
			check_value({tag, " fail"}, 72'(VECTORS[i].fail), 72'(fail));
			check_value({tag, " tetris"}, VECTORS[i].board, tetris);
			// pulse is exactly one cycle
			@(negedge clk);
			check_idle_outputs({tag, " after result"});
		end

		finish_run();
	end

endmodule

// File: src.f
+incdir+testbench
logic/tetris_pkg.sv
logic/line_check.sv
logic/drop_calc.sv
logic/board_store.sv
logic/game_ctrl.sv
logic/tetris_top.sv
testbench/tb_tetris.sv

// File: Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f src.f --top-module tb_tetris
	verilator --lint-only -f src.f --top-module tetris_top

sim:
	verilator --binary --timing --assert -f src.f --top-module tb_tetris -Mdir obj_dir
	./obj_dir/Vtb_tetris | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log
